// File: src/rvfi_monitor_pkg.sv
package rvfi_monitor_pkg;

    // widths with a meaning on the RVFI side
    typedef logic [31:0] xlen_word_t;   // insn, pc, register or data word
    typedef logic [4:0]  reg_addr_t;
    typedef logic [63:0] order_t;

    typedef enum logic [1:0] {
        mon_idle   = 2'd0, // no retirement seen yet
        mon_run    = 2'd1,
        mon_halted = 2'd2,
        mon_fault  = 2'd3  // sticky until reset
    } mon_state_t;

    // lower value wins when several errors hit the same retirement
    typedef enum logic [2:0] {
        cause_none       = 3'd0,
        cause_order      = 3'd1,
        cause_pc         = 3'd2,
        cause_x0_write   = 3'd3,
        cause_rs1        = 3'd4,
        cause_rs2        = 3'd5,
        cause_after_halt = 3'd6
    } fault_cause_t;

    typedef logic [2:0] counter_sel_t;

    // counter select codes
    localparam counter_sel_t sel_cycles     = 3'd0;
    localparam counter_sel_t sel_retired    = 3'd1;
    localparam counter_sel_t sel_traps      = 3'd2;
    localparam counter_sel_t sel_intrs      = 3'd3;
    localparam counter_sel_t sel_loads      = 3'd4;
    localparam counter_sel_t sel_stores     = 3'd5;
    localparam counter_sel_t sel_ctrl_xfers = 3'd6;
    localparam counter_sel_t sel_zero       = 3'd7;  // reads as zero

    // number of implemented counters, code 7 has none behind it
    localparam int num_counters = 7;

    // instruction length assumed for sequential flow
    localparam xlen_word_t insn_step = 32'd4;

endpackage

// File: src/rvfi_monitor_ctrl.sv
`timescale 1ns/1ps

module rvfi_monitor_ctrl import rvfi_monitor_pkg::*; (
    input  logic         rvfi_ext_clk,
    input  logic         rvfi_ext_reset_n,
    input  logic         rvfi_valid,
    input  logic         rvfi_halt,
    input  order_t       rvfi_order,
    input  logic         order_err,
    input  logic         pc_err,
    input  logic         x0_err,
    input  logic         rs1_err,
    input  logic         rs2_err,
    output logic         check_en,
    output mon_state_t   mon_state,
    output logic         fault,
    output fault_cause_t fault_cause,
    output order_t       fault_order
);

    mon_state_t   state_q, state_d;
    fault_cause_t cause_q;
    order_t       order_q;
    fault_cause_t err_cause;   // highest priority error of this retirement
    fault_cause_t new_cause;
    logic         latch;

    // history only exists while running
    assign check_en = (state_q == mon_run);

    always_comb begin
        err_cause = cause_none;
        if (check_en) begin
            if (order_err)
                err_cause = cause_order;
            else if (pc_err)
                err_cause = cause_pc;
            else if (x0_err)
                err_cause = cause_x0_write;
            else if (rs1_err)
                err_cause = cause_rs1;
            else if (rs2_err)
                err_cause = cause_rs2;
        end
    end

    always_comb begin
        state_d   = state_q;
        latch     = 1'b0;
        new_cause = err_cause;
        case (state_q)
            mon_idle: begin
                if (rvfi_valid)
                    state_d = rvfi_halt ? mon_halted : mon_run;
            end
            mon_run: begin
                if (rvfi_valid && err_cause != cause_none) begin
                    state_d = mon_fault;
                    latch   = 1'b1;
                end else if (rvfi_valid && rvfi_halt) begin
                    state_d = mon_halted;
                end
            end
            mon_halted: begin
                if (rvfi_valid) begin   // nothing may retire after a halt
                    state_d   = mon_fault;
                    latch     = 1'b1;
                    new_cause = cause_after_halt;
                end
            end
            default: state_d = state_q;  // fault holds
        endcase
    end

    always_ff @(posedge rvfi_ext_clk or negedge rvfi_ext_reset_n) begin
        if (!rvfi_ext_reset_n) begin
            state_q <= mon_idle;
            cause_q <= cause_none;
            order_q <= '0;
        end else begin
            state_q <= state_d;
            if (latch) begin    // only ever once per reset
                cause_q <= new_cause;
                order_q <= rvfi_order;
            end
        end
    end

    assign mon_state   = state_q;
    assign fault       = (state_q == mon_fault);
    assign fault_cause = cause_q;
    assign fault_order = order_q;

endmodule

// File: src/rvfi_flow_check.sv
`timescale 1ns/1ps

module rvfi_flow_check import rvfi_monitor_pkg::*; (
    input  logic       rvfi_ext_clk,
    input  logic       rvfi_ext_reset_n,
    input  logic       rvfi_valid,
    input  logic       check_en,
    input  order_t     rvfi_order,
    input  logic       rvfi_intr,
    input  reg_addr_t  rvfi_rd_addr,
    input  xlen_word_t rvfi_rd_wdata,
    input  xlen_word_t rvfi_pc_rdata,
    input  xlen_word_t rvfi_pc_wdata,
    output logic       order_err,
    output logic       pc_err,
    output logic       x0_err
);

    order_t     prev_order_q;
    xlen_word_t next_pc_q;     // pc_wdata of the previous retirement
    order_t     exp_order;

    assign exp_order = prev_order_q + order_t'(1);

    // order must step by exactly one per retirement
    assign order_err = rvfi_valid && check_en && (rvfi_order != exp_order);

    // an interrupt entry may redirect the pc
    assign pc_err = rvfi_valid && check_en && !rvfi_intr
                    && (rvfi_pc_rdata != next_pc_q);

    // no history needed here, the control module decides when it counts
    assign x0_err = rvfi_valid && (rvfi_rd_addr == reg_addr_t'(0))
                    && (rvfi_rd_wdata != '0);

    always_ff @(posedge rvfi_ext_clk or negedge rvfi_ext_reset_n) begin
        if (!rvfi_ext_reset_n) begin
            prev_order_q <= '0;
            next_pc_q    <= '0;
        end else if (rvfi_valid) begin
            prev_order_q <= rvfi_order;
            next_pc_q    <= rvfi_pc_wdata;   // traps too, pc_wdata is the handler
        end
    end

endmodule

// File: src/rvfi_reg_shadow.sv
`timescale 1ns/1ps

module rvfi_reg_shadow import rvfi_monitor_pkg::*; (
    input  logic       rvfi_ext_clk,
    input  logic       rvfi_ext_reset_n,
    input  logic       rvfi_valid,
    input  logic       rvfi_trap,
    input  reg_addr_t  rvfi_rs1_addr,
    input  reg_addr_t  rvfi_rs2_addr,
    input  xlen_word_t rvfi_rs1_rdata,
    input  xlen_word_t rvfi_rs2_rdata,
    input  reg_addr_t  rvfi_rd_addr,
    input  xlen_word_t rvfi_rd_wdata,
    output logic       rs1_err,
    output logic       rs2_err
);

    xlen_word_t shadow_q [1:31];  // x1..x31, x0 has no storage
    logic [31:1] known_q;         // set once a register was written back
    logic        wr_en;

    // x0 reads zero, unknown registers are accepted as read
    function automatic logic read_bad(input reg_addr_t  addr,
                                      input xlen_word_t rdata,
                                      input logic [31:1] known,
                                      input xlen_word_t value);
        logic bad;
        if (addr == reg_addr_t'(0))
            bad = (rdata != '0);
        else if (known[addr])
            bad = (rdata != value);
        else
            bad = 1'b0;
        return bad;
    endfunction

    xlen_word_t rs1_shadow;
    xlen_word_t rs2_shadow;

    always_comb begin
        rs1_shadow = '0;
        rs2_shadow = '0;
        if (rvfi_rs1_addr != reg_addr_t'(0))
            rs1_shadow = shadow_q[rvfi_rs1_addr];
        if (rvfi_rs2_addr != reg_addr_t'(0))
            rs2_shadow = shadow_q[rvfi_rs2_addr];
    end

    // reads see the state before this retirement's writeback
    assign rs1_err = rvfi_valid && read_bad(rvfi_rs1_addr, rvfi_rs1_rdata, known_q, rs1_shadow);
    assign rs2_err = rvfi_valid && read_bad(rvfi_rs2_addr, rvfi_rs2_rdata, known_q, rs2_shadow);

    // a trapped instruction does not write back
    assign wr_en = rvfi_valid && !rvfi_trap && (rvfi_rd_addr != reg_addr_t'(0));

    always_ff @(posedge rvfi_ext_clk) begin
        if (wr_en)
            shadow_q[rvfi_rd_addr] <= rvfi_rd_wdata;
    end

    always_ff @(posedge rvfi_ext_clk or negedge rvfi_ext_reset_n) begin
        if (!rvfi_ext_reset_n)
            known_q <= '0;
        else if (wr_en)
            known_q[rvfi_rd_addr] <= 1'b1;
    end

endmodule

// File: src/rvfi_perf_counters.sv
`timescale 1ns/1ps

module rvfi_perf_counters import rvfi_monitor_pkg::*; #(
    parameter int COUNTER_W = 32
) (
    input  logic                 rvfi_ext_clk,
    input  logic                 rvfi_ext_reset_n,
    input  logic                 rvfi_valid,
    input  logic                 rvfi_trap,
    input  logic                 rvfi_intr,
    input  logic [3:0]           rvfi_mem_rmask,
    input  logic [3:0]           rvfi_mem_wmask,
    input  xlen_word_t           rvfi_pc_rdata,
    input  xlen_word_t           rvfi_pc_wdata,
    input  counter_sel_t         counter_sel,
    output logic [COUNTER_W-1:0] counter_value
);

    typedef logic [COUNTER_W-1:0] count_t;

    count_t                  cnt_q [num_counters];
    logic [num_counters-1:0] event_hit;
    xlen_word_t              seq_pc;

    assign seq_pc = rvfi_pc_rdata + insn_step;

    // one increment strobe per counter, indexed by select code
    always_comb begin
        event_hit                 = '0;
        event_hit[sel_cycles]     = 1'b1;  // free running
        event_hit[sel_retired]    = rvfi_valid;
        event_hit[sel_traps]      = rvfi_valid && rvfi_trap;
        event_hit[sel_intrs]      = rvfi_valid && rvfi_intr;
        event_hit[sel_loads]      = rvfi_valid && (rvfi_mem_rmask != 4'b0000);
        event_hit[sel_stores]     = rvfi_valid && (rvfi_mem_wmask != 4'b0000);
        event_hit[sel_ctrl_xfers] = rvfi_valid && (rvfi_pc_wdata != seq_pc);
    end

    always_ff @(posedge rvfi_ext_clk or negedge rvfi_ext_reset_n) begin
        if (!rvfi_ext_reset_n) begin
            for (int i = 0; i < num_counters; i++)
                cnt_q[i] <= '0;
        end else begin
            for (int i = 0; i < num_counters; i++) begin
                if (event_hit[i])
                    cnt_q[i] <= cnt_q[i] + count_t'(1);  // wraps
            end
        end
    end

    // same cycle read of the registered counters
    always_comb begin
        if (counter_sel == sel_zero)
            counter_value = '0;
        else
            counter_value = cnt_q[counter_sel];
    end

endmodule

// File: src/rvfi_monitor.sv
`timescale 1ns/1ps

module rvfi_monitor import rvfi_monitor_pkg::*; #(
    parameter int COUNTER_W = 32
) (
    input  logic                 rvfi_ext_clk,
    input  logic                 rvfi_ext_reset_n,
    input  logic                 rvfi_valid,
    input  order_t               rvfi_order,
    input  xlen_word_t           rvfi_insn,
    input  logic                 rvfi_trap,
    input  logic                 rvfi_halt,
    input  logic                 rvfi_intr,
    input  logic [1:0]           rvfi_mode,
    input  logic [1:0]           rvfi_ixl,
    input  reg_addr_t            rvfi_rs1_addr,
    input  reg_addr_t            rvfi_rs2_addr,
    input  xlen_word_t           rvfi_rs1_rdata,
    input  xlen_word_t           rvfi_rs2_rdata,
    input  reg_addr_t            rvfi_rd_addr,
    input  xlen_word_t           rvfi_rd_wdata,
    input  xlen_word_t           rvfi_pc_rdata,
    input  xlen_word_t           rvfi_pc_wdata,
    input  xlen_word_t           rvfi_mem_addr,
    input  logic [3:0]           rvfi_mem_rmask,
    input  logic [3:0]           rvfi_mem_wmask,
    input  xlen_word_t           rvfi_mem_rdata,
    input  xlen_word_t           rvfi_mem_wdata,
    input  counter_sel_t         counter_sel,
    output mon_state_t           mon_state,
    output logic                 fault,
    output fault_cause_t         fault_cause,
    output order_t               fault_order,
    output logic [COUNTER_W-1:0] counter_value
);

    logic check_en;
    logic order_err, pc_err, x0_err;   // from the flow check
    logic rs1_err, rs2_err;            // from the shadow file

    rvfi_monitor_ctrl ctrl_i (
        .rvfi_ext_clk, .rvfi_ext_reset_n, .rvfi_valid, .rvfi_halt, .rvfi_order,
        .order_err, .pc_err, .x0_err, .rs1_err, .rs2_err,
        .check_en, .mon_state, .fault, .fault_cause, .fault_order
    );

    rvfi_flow_check flow_i (
        .rvfi_ext_clk, .rvfi_ext_reset_n, .rvfi_valid, .check_en, .rvfi_order,
        .rvfi_intr, .rvfi_rd_addr, .rvfi_rd_wdata, .rvfi_pc_rdata, .rvfi_pc_wdata,
        .order_err, .pc_err, .x0_err
    );

    rvfi_reg_shadow shadow_i (
        .rvfi_ext_clk, .rvfi_ext_reset_n, .rvfi_valid, .rvfi_trap,
        .rvfi_rs1_addr, .rvfi_rs2_addr, .rvfi_rs1_rdata, .rvfi_rs2_rdata,
        .rvfi_rd_addr, .rvfi_rd_wdata, .rs1_err, .rs2_err
    );

    rvfi_perf_counters #(.COUNTER_W(COUNTER_W)) perf_i (
        .rvfi_ext_clk, .rvfi_ext_reset_n, .rvfi_valid, .rvfi_trap, .rvfi_intr,
        .rvfi_mem_rmask, .rvfi_mem_wmask, .rvfi_pc_rdata, .rvfi_pc_wdata,
        .counter_sel, .counter_value
    );

endmodule

// File: bench/rvfi_monitor_chk.sv
`timescale 1ns/1ps

module rvfi_monitor_chk import rvfi_monitor_pkg::*; (
    input logic         rvfi_ext_clk,
    input logic         rvfi_ext_reset_n,
    input logic         fault,
    input fault_cause_t fault_cause,
    input mon_state_t   mon_state
);

    // fault is sticky until reset
    fault_sticky: assert property (
        @(posedge rvfi_ext_clk) disable iff (!rvfi_ext_reset_n)
        fault |=> fault
    ) else $error("fault dropped without a reset");

    // a cause is latched exactly when faulted
    cause_matches_fault: assert property (
        @(posedge rvfi_ext_clk) disable iff (!rvfi_ext_reset_n)
        (fault_cause != cause_none) == fault
    ) else $error("fault_cause and fault disagree");

    // a fault needs a retirement history, so never straight from idle
    fault_entry: assert property (
        @(posedge rvfi_ext_clk) disable iff (!rvfi_ext_reset_n)
        $rose(fault) |-> ($past(mon_state) == mon_run || $past(mon_state) == mon_halted)
    ) else $error("fault entered without a run or halt before it");

endmodule

bind rvfi_monitor rvfi_monitor_chk chk_i (
    .rvfi_ext_clk     (rvfi_ext_clk),
    .rvfi_ext_reset_n (rvfi_ext_reset_n),
    .fault            (fault),
    .fault_cause      (fault_cause),
    .mon_state        (mon_state)
);

// File: bench/rvfi_monitor_tb.sv
`timescale 1ns/1ps

module rvfi_monitor_tb import rvfi_monitor_pkg::*; ();

    localparam int COUNTER_W = 32;
    typedef logic [COUNTER_W-1:0] count_t;

    logic         rvfi_ext_clk = 1'b0;
    logic         rvfi_ext_reset_n = 1'b0;
    logic         rvfi_valid = 1'b0;
    order_t       rvfi_order = '0;
    xlen_word_t   rvfi_insn = 32'h0000_0013;
    logic         rvfi_trap = 1'b0;
    logic         rvfi_halt = 1'b0;
    logic         rvfi_intr = 1'b0;
    logic [1:0]   rvfi_mode = 2'd3;
    logic [1:0]   rvfi_ixl = 2'd1;
    reg_addr_t    rvfi_rs1_addr = '0;
    reg_addr_t    rvfi_rs2_addr = '0;
    xlen_word_t   rvfi_rs1_rdata = '0;
    xlen_word_t   rvfi_rs2_rdata = '0;
    reg_addr_t    rvfi_rd_addr = '0;
    xlen_word_t   rvfi_rd_wdata = '0;
    xlen_word_t   rvfi_pc_rdata = '0;
    xlen_word_t   rvfi_pc_wdata = '0;
    xlen_word_t   rvfi_mem_addr = '0;
    logic [3:0]   rvfi_mem_rmask = '0;
    logic [3:0]   rvfi_mem_wmask = '0;
    xlen_word_t   rvfi_mem_rdata = '0;
    xlen_word_t   rvfi_mem_wdata = '0;
    counter_sel_t counter_sel = '0;
    mon_state_t   mon_state;
    logic         fault;
    fault_cause_t fault_cause;
    order_t       fault_order;
    count_t       counter_value;

    int val_errs = 0;
    int other_errs = 0;
    integer seed = 20;

    // reference model state
    mon_state_t   m_state;
    fault_cause_t m_cause;
    order_t       m_forder;
    order_t       m_prev;
    xlen_word_t   m_npc;
    xlen_word_t   m_regs [32];
    logic [31:0]  m_known;
    count_t       m_cnt [8];

    // stimulus generator state, the next retirement sits in n_*
    order_t     g_order;
    xlen_word_t g_pc;
    xlen_word_t g_regs [16];   // only x0..x15 are ever written
    order_t     n_order;
    xlen_word_t n_pc, n_npc, n_wd, n_rs1d, n_rs2d;
    reg_addr_t  n_rd, n_rs1a, n_rs2a;
    logic       n_trap, n_intr, n_halt;
    logic [3:0] n_rmask, n_wmask;

    rvfi_monitor #(.COUNTER_W(COUNTER_W)) dut_i (.*);

    always #2 rvfi_ext_clk = ~rvfi_ext_clk;

    function automatic logic read_wrong(input reg_addr_t a, input xlen_word_t d);
        if (a == 5'd0)
            return d != '0;
        return m_known[a] && (d != m_regs[a]);
    endfunction

    // cause that the presented retirement should raise
    function automatic fault_cause_t expect_cause();
        if (m_state == mon_halted)
            return cause_after_halt;
        if (m_state != mon_run)
            return cause_none;
        if (rvfi_order != m_prev + 64'd1)
            return cause_order;
        if (!rvfi_intr && rvfi_pc_rdata != m_npc)
            return cause_pc;
        if (rvfi_rd_addr == 5'd0 && rvfi_rd_wdata != '0)
            return cause_x0_write;
        if (read_wrong(rvfi_rs1_addr, rvfi_rs1_rdata))
            return cause_rs1;
        if (read_wrong(rvfi_rs2_addr, rvfi_rs2_rdata))
            return cause_rs2;
        return cause_none;
    endfunction

    always @(posedge rvfi_ext_clk or negedge rvfi_ext_reset_n) begin
        fault_cause_t c;
        if (!rvfi_ext_reset_n) begin
            m_state  = mon_idle;
            m_cause  = cause_none;
            m_forder = '0;
            m_prev   = '0;
            m_npc    = '0;
            m_known  = '0;
            for (int i = 0; i < 8; i++)
                m_cnt[i] = '0;
        end else begin
            m_cnt[0] = m_cnt[0] + 1'b1;   // cycles
            if (rvfi_valid) begin
                c = expect_cause();
                case (m_state)
                    mon_idle: m_state = rvfi_halt ? mon_halted : mon_run;
                    mon_run: begin
                        if (c != cause_none) begin
                            m_state  = mon_fault;
                            m_cause  = c;
                            m_forder = rvfi_order;
                        end else if (rvfi_halt) begin
                            m_state = mon_halted;
                        end
                    end
                    mon_halted: begin
                        m_state  = mon_fault;
                        m_cause  = c;
                        m_forder = rvfi_order;
                    end
                    default: ;
                endcase
                m_prev = rvfi_order;
                m_npc  = rvfi_pc_wdata;
                if (!rvfi_trap && rvfi_rd_addr != 5'd0) begin
                    m_regs[rvfi_rd_addr]  = rvfi_rd_wdata;
                    m_known[rvfi_rd_addr] = 1'b1;
                end
                m_cnt[1] = m_cnt[1] + 1'b1;
                m_cnt[2] = m_cnt[2] + count_t'(rvfi_trap);
                m_cnt[3] = m_cnt[3] + count_t'(rvfi_intr);
                m_cnt[4] = m_cnt[4] + count_t'(rvfi_mem_rmask != 4'd0);
                m_cnt[5] = m_cnt[5] + count_t'(rvfi_mem_wmask != 4'd0);
                m_cnt[6] = m_cnt[6] + count_t'(rvfi_pc_wdata != rvfi_pc_rdata + 32'd4);
            end
        end
    end

    task automatic check_state(input mon_state_t exp, input mon_state_t act);
        if (exp !== act) begin
            val_errs++;
            $display("ERR mon_state expected %h got %h at %0t", exp, act, $time);
        end
    endtask

    task automatic check_cause(input fault_cause_t exp, input fault_cause_t act);
        if (exp !== act) begin
            val_errs++;
            $display("ERR fault_cause expected %h got %h at %0t", exp, act, $time);
        end
    endtask

    task automatic check_order(input order_t exp, input order_t act);
        if (exp !== act) begin
            val_errs++;
            $display("ERR fault_order expected %h got %h at %0t", exp, act, $time);
        end
    endtask

    task automatic check_flag(input logic exp, input logic act);
        if (exp !== act) begin
            val_errs++;
            $display("ERR fault expected %h got %h at %0t", exp, act, $time);
        end
    endtask

    task automatic check_counter(input counter_sel_t sel, input count_t exp, input count_t act);
        if (exp !== act) begin
            val_errs++;
            $display("ERR counter_value[%0d] expected %h got %h", sel, exp, act);
        end
    endtask

    // compare the registered outputs one edge after each retirement
    always @(negedge rvfi_ext_clk) begin
        if (rvfi_ext_reset_n) begin
            check_state(m_state, mon_state);
            check_flag(m_state == mon_fault, fault);
            check_cause(m_cause, fault_cause);
            check_order(m_forder, fault_order);
        end
    end

    task automatic read_counters();
        for (int s = 0; s < 8; s++) begin
            @(posedge rvfi_ext_clk);
            #1 counter_sel = counter_sel_t'(s);
            @(negedge rvfi_ext_clk);
            check_counter(counter_sel_t'(s), (s == 7) ? count_t'(0) : m_cnt[s], counter_value);
        end
    endtask

    task automatic do_reset();
        @(posedge rvfi_ext_clk);
        #1;
        rvfi_ext_reset_n = 1'b0;
        rvfi_valid = 1'b0;
        read_counters();   // 8 cycles in reset, all must read zero
        check_state(mon_idle, mon_state);
        check_flag(1'b0, fault);
        check_cause(cause_none, fault_cause);
        check_order('0, fault_order);
        @(posedge rvfi_ext_clk);
        #1 rvfi_ext_reset_n = 1'b1;
        g_order = 64'd0;
        g_pc = 32'h0000_1000;
    endtask

    // build one legal retirement and advance the generator
    task automatic make_insn();
        logic [31:0] r;
        r = $random(seed);
        n_order = g_order;
        n_pc = g_pc;
        n_intr = (r[7:5] == 3'd0);
        if (n_intr)
            n_pc = 32'h0000_0200;   // interrupt vector
        n_rs1a = reg_addr_t'(r[11:8]);
        n_rs2a = reg_addr_t'(r[15:12]);
        n_rs1d = g_regs[r[11:8]];
        n_rs2d = g_regs[r[15:12]];
        n_rd = reg_addr_t'(r[19:16]);
        n_wd = $random(seed);
        if (n_rd == 5'd0)
            n_wd = '0;
        n_rmask = r[20] ? 4'hf : 4'h0;
        n_wmask = (r[21] && !r[20]) ? 4'h3 : 4'h0;
        n_trap = (r[24:22] == 3'd0);
        n_halt = 1'b0;
        if (n_trap)
            n_npc = 32'h0000_0100;
        else if (r[27:25] == 3'd0)
            n_npc = n_pc + 32'd8 + {24'd0, r[31:28], 4'd0};   // jump
        else
            n_npc = n_pc + 32'd4;
        if (!n_trap && n_rd != 5'd0)
            g_regs[r[19:16]] = n_wd;
        g_order = g_order + 64'd1;
        g_pc = n_npc;
    endtask

    task automatic drive_insn();
        @(posedge rvfi_ext_clk);
        #1;
        rvfi_valid = 1'b1;
        rvfi_order = n_order;
        rvfi_pc_rdata = n_pc;
        rvfi_pc_wdata = n_npc;
        rvfi_rs1_addr = n_rs1a;
        rvfi_rs1_rdata = n_rs1d;
        rvfi_rs2_addr = n_rs2a;
        rvfi_rs2_rdata = n_rs2d;
        rvfi_rd_addr = n_rd;
        rvfi_rd_wdata = n_wd;
        rvfi_trap = n_trap;
        rvfi_intr = n_intr;
        rvfi_halt = n_halt;
        rvfi_mem_rmask = n_rmask;
        rvfi_mem_wmask = n_wmask;
    endtask

    task automatic bubble();
        @(posedge rvfi_ext_clk);
        #1 rvfi_valid = 1'b0;
    endtask

    task automatic good(input int n);
        for (int i = 0; i < n; i++) begin
            make_insn();
            drive_insn();
        end
    endtask

    task automatic wait_state(input mon_state_t want);
        int i;
        i = 0;
        while (mon_state != want && i < 20) begin
            @(negedge rvfi_ext_clk);
            i++;
        end
        if (mon_state != want) begin
            other_errs++;
            $display("timeout: monitor never reached state %s", want.name());
        end
    endtask

    initial begin
        #400000;
        $display("timeout: the test sequence did not finish");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        order_t bad;
        for (int i = 0; i < 16; i++)
            g_regs[i] = '0;
        do_reset();
        // clean program with bubbles
        for (int i = 0; i < 400; i++) begin
            if ($random(seed) % 5 == 0)
                bubble();
            else
                good(1);
        end
        bubble();
        read_counters();
        check_state(mon_run, mon_state);

        do_reset();
        good(5);
        make_insn();
        n_order = n_order + 64'd1;   // skipped order number
        bad = n_order;
        drive_insn();
        bubble();
        wait_state(mon_fault);
        check_cause(cause_order, fault_cause);
        check_order(bad, fault_order);

        do_reset();
        good(3);
        make_insn();
        n_pc = n_pc + 32'd8;
        n_intr = 1'b0;
        drive_insn();
        bubble();
        wait_state(mon_fault);
        check_cause(cause_pc, fault_cause);

        do_reset();
        good(3);
        make_insn();
        n_pc = n_pc + 32'd8;
        n_intr = 1'b1;   // interrupt entry may jump
        drive_insn();
        make_insn();
        n_rs1a = 5'd31;  // never written, any data passes
        n_rs1d = 32'hdead_beef;
        drive_insn();
        bubble();
        check_state(mon_run, mon_state);

        do_reset();
        good(2);
        make_insn();
        n_rd = 5'd0;
        n_wd = 32'd1;
        drive_insn();
        bubble();
        wait_state(mon_fault);
        check_cause(cause_x0_write, fault_cause);

        do_reset();
        good(2);
        make_insn();
        n_trap = 1'b0;
        n_rd = 5'd5;
        n_wd = 32'h0000_1234;
        g_regs[5] = n_wd;
        drive_insn();
        make_insn();
        n_rs1a = 5'd0;   // only rs2 may be wrong here
        n_rs1d = '0;
        n_rs2a = 5'd5;
        n_rs2d = 32'h0000_1235;
        drive_insn();
        bubble();
        wait_state(mon_fault);
        check_cause(cause_rs2, fault_cause);

        do_reset();
        good(2);
        make_insn();
        n_trap = 1'b0;
        n_rd = 5'd5;
        n_wd = 32'h0000_00aa;
        g_regs[5] = n_wd;
        drive_insn();
        make_insn();
        n_order = n_order + 64'd2;   // order and rs2 wrong together
        bad = n_order;
        n_rs2a = 5'd5;
        n_rs2d = 32'h0000_00ab;
        drive_insn();
        bubble();
        wait_state(mon_fault);
        check_cause(cause_order, fault_cause);
        // later bad retirements must not move the latched fault
        for (int i = 0; i < 6; i++) begin
            make_insn();
            n_order = n_order + 64'd7;
            n_rd = 5'd0;
            n_wd = 32'd9;
            drive_insn();
        end
        bubble();
        check_cause(cause_order, fault_cause);
        check_order(bad, fault_order);
        read_counters();

        do_reset();
        good(3);
        make_insn();
        n_halt = 1'b1;
        drive_insn();
        bubble();
        wait_state(mon_halted);
        check_flag(1'b0, fault);
        make_insn();
        bad = n_order;
        drive_insn();
        bubble();
        wait_state(mon_fault);
        check_cause(cause_after_halt, fault_cause);
        check_order(bad, fault_order);
        read_counters();

        $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: list.f
src/rvfi_monitor_pkg.sv
src/rvfi_monitor_ctrl.sv
src/rvfi_flow_check.sv
src/rvfi_reg_shadow.sv
src/rvfi_perf_counters.sv
src/rvfi_monitor.sv
bench/rvfi_monitor_chk.sv
bench/rvfi_monitor_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rvfi_monitor_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "run failed"; exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "run ended early"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
